/* alut/alut_addr_checker.sv */
// destination lookup and source learning for one frame per cmd_check
// always two reads then one write, latency stretches under arbitration
// frame registers must stay stable while add_check_active is high
`timescale 1ns/1ps
`default_nettype none

module alut_addr_checker (
   input  wire                                 pclk24,
   input  wire                                 n_p_reset24,
   input  wire  alut_reg_pkg::alut_cmd_e       command,
   input  wire  alut_reg_pkg::alut_frame_t     frame,
   input  wire  [47:0]                         mac_addr,
   input  wire  [31:0]                         curr_time,
   input  wire                                 clear_reused,
   input  wire                                 grant,
   input  wire                                 rvalid,
   input  wire  alut_table_pkg::alut_entry_t   rentry,
   output alut_table_pkg::alut_mem_req_t       mem_req,
   output logic [alut_table_pkg::N_PORTS:0]    d_port,
   output logic                                add_check_active,
   output logic                                reused,
   output alut_table_pkg::alut_inv_t           lst_inv_nrm
);

   import alut_reg_pkg::*;
   import alut_table_pkg::*;

   typedef enum logic [2:0] {idle, rd_dst, cmp_dst, rd_src, wr_src} alut_chk_state_e;

   alut_chk_state_e    state;
   logic [N_PORTS-1:0] hit_mask;     // one-hot of the stored port
   logic [N_PORTS-1:0] src_mask;     // one-hot of the ingress port
   logic               overwrite;    // source slot held someone else

   assign hit_mask         = N_PORTS'(1) << rentry.port;
   assign src_mask         = N_PORTS'(1) << frame.s_port;
   assign add_check_active = (state != idle);
   assign overwrite        = (state == wr_src) && rvalid && rentry.valid &&
                             (rentry.mac != frame.s_addr);

   always_ff @(posedge pclk24 or negedge n_p_reset24)
   begin
      if (!n_p_reset24)
         state <= idle;
      else
      begin
         case (state)
            idle    : if (command == cmd_check) state <= rd_dst;   // busy drops it
            rd_dst  : if (grant) state <= cmp_dst;
            cmp_dst : if (rvalid) state <= rd_src;
            rd_src  : if (grant) state <= wr_src;
            wr_src  : if (grant) state <= idle;     // src data arrives on entry
            default : state <= idle;
         endcase
      end
   end

   always_comb
   begin
      mem_req = '0;
      case (state)
         rd_dst :
         begin
            mem_req.req = 1'b1;
            mem_req.idx = slot_idx(frame.d_addr);
         end
         rd_src :
         begin
            mem_req.req = 1'b1;
            mem_req.idx = slot_idx(frame.s_addr);
         end
         wr_src :
         begin
            mem_req.req    = 1'b1;
            mem_req.we     = 1'b1;
            mem_req.idx    = slot_idx(frame.s_addr);
            mem_req.wentry = '{valid: 1'b1, mac: frame.s_addr, port: frame.s_port,
                               stamp: curr_time};
         end
         default : ;
      endcase
   end

   // ----------------------------------------------------------------------
   // lookup result and reuse flag
   // ----------------------------------------------------------------------
   always_ff @(posedge pclk24 or negedge n_p_reset24)
   begin
      if (!n_p_reset24)
      begin
         d_port <= '0;
         reused <= 1'b0;
      end
      else
      begin
         if (state == cmp_dst && rvalid)
         begin
            if (frame.d_addr == mac_addr)
               d_port <= {1'b1, {N_PORTS{1'b0}}};     // for the switch itself
            else if (rentry.valid && rentry.mac == frame.d_addr)
               d_port <= {1'b0, hit_mask};
            else
               d_port <= {1'b0, ~src_mask};           // flood, not back out
         end
         if (overwrite)
            reused <= 1'b1;                          // sticky until acked
         else if (clear_reused)
            reused <= 1'b0;
      end
   end

   always_ff @(posedge pclk24)
   begin
      if (overwrite)
         lst_inv_nrm <= '{addr: rentry.mac, port: rentry.port};
   end

endmodule

`default_nettype wire

/* alut/alut_age_checker.sv */
// free-running time base and the aging sweep over all slots
// curr_time steps once every div_clk+1 cycles and wraps silently
// an entry expires when curr_time - stamp exceeds best_bfr_age
`timescale 1ns/1ps
`default_nettype none

module alut_age_checker (
   input  wire                                 pclk24,
   input  wire                                 n_p_reset24,
   input  wire  alut_reg_pkg::alut_cmd_e       command,
   input  wire  [7:0]                          div_clk,
   input  wire  [31:0]                         best_bfr_age,
   input  wire                                 grant,
   input  wire                                 rvalid,
   input  wire  alut_table_pkg::alut_entry_t   rentry,
   output alut_table_pkg::alut_mem_req_t       mem_req,
   output logic [31:0]                         curr_time,
   output logic                                age_check_active,
   output logic                                inval_in_prog,
   output alut_table_pkg::alut_inv_t           lst_inv_cmd
);

   import alut_reg_pkg::*;
   import alut_table_pkg::*;

   typedef enum logic [1:0] {idle, rd_slot, chk_slot, inv_slot} alut_age_state_e;

   alut_age_state_e  state;
   logic [7:0]       div_cnt;
   logic [IDX_W-1:0] idx;          // sweep position
   alut_entry_t      stale;        // entry about to be dropped
   logic             last_slot;
   logic             expired;

   assign last_slot        = (idx == IDX_W'(TABLE_DEPTH - 1));
   assign expired          = rentry.valid && ((curr_time - rentry.stamp) > best_bfr_age);
   assign age_check_active = (state != idle);

   // prescaler
   always_ff @(posedge pclk24 or negedge n_p_reset24)
   begin
      if (!n_p_reset24)
      begin
         div_cnt   <= '0;
         curr_time <= '0;
      end
      else if (div_cnt >= div_clk)     // >= so a smaller div_clk takes at once
      begin
         div_cnt   <= '0;
         curr_time <= curr_time + 32'd1;
      end
      else
         div_cnt <= div_cnt + 8'd1;
   end

   // ----------------------------------------------------------------------
   // sweep FSM
   // ----------------------------------------------------------------------
   always_ff @(posedge pclk24 or negedge n_p_reset24)
   begin
      if (!n_p_reset24)
      begin
         state         <= idle;
         idx           <= '0;
         inval_in_prog <= 1'b0;
      end
      else
      begin
         inval_in_prog <= 1'b0;                    // single pulse
         case (state)
            idle :
               if (command == cmd_age)
               begin
                  idx   <= '0;
                  state <= rd_slot;
               end
            rd_slot : if (grant) state <= chk_slot;
            chk_slot :
               if (rvalid)
               begin
                  if (expired)
                     state <= inv_slot;
                  else if (last_slot)
                     state <= idle;
                  else
                  begin
                     idx   <= idx + 1'b1;
                     state <= rd_slot;
                  end
               end
            inv_slot :
               if (grant)
               begin
                  inval_in_prog <= 1'b1;
                  idx           <= idx + 1'b1;          // wraps to 0 after last
                  state         <= last_slot ? idle : rd_slot;
               end
            default : state <= idle;
         endcase
      end
   end

   always_ff @(posedge pclk24)
   begin
      if (state == chk_slot && rvalid)
         stale <= rentry;
      if (state == inv_slot && grant)
         lst_inv_cmd <= '{addr: stale.mac, port: stale.port};
   end

   always_comb
   begin
      mem_req     = '0;
      mem_req.idx = idx;
      if (state == rd_slot)
         mem_req.req = 1'b1;
      else if (state == inv_slot)
      begin
         mem_req.req          = 1'b1;
         mem_req.we           = 1'b1;
         mem_req.wentry       = stale;
         mem_req.wentry.valid = 1'b0;          // only the valid bit matters
      end
   end

endmodule

`default_nettype wire

/* alut/alut_reg_bank.sv */
// APB register bank of the lookup block, no pready and no pslverr
// read data is taken in the setup phase and held for one cycle only
// command is a one-cycle pulse, value 3 is dropped
`timescale 1ns/1ps
`default_nettype none

module alut_reg_bank (
   input  wire                                 pclk24,
   input  wire                                 n_p_reset24,
   input  wire                                 psel,
   input  wire                                 penable,
   input  wire                                 pwrite,
   input  wire  [6:0]                          paddr,
   input  wire  [31:0]                         pwdata,
   input  wire  [31:0]                         curr_time,
   input  wire                                 add_check_active,
   input  wire                                 age_check_active,
   input  wire                                 inval_in_prog,
   input  wire                                 reused,
   input  wire  [alut_table_pkg::N_PORTS:0]    d_port,
   input  wire  alut_table_pkg::alut_inv_t     lst_inv_nrm,
   input  wire  alut_table_pkg::alut_inv_t     lst_inv_cmd,
   output alut_reg_pkg::alut_frame_t           frame,
   output logic [47:0]                         mac_addr,
   output logic [31:0]                         best_bfr_age,
   output logic [7:0]                          div_clk,
   output alut_reg_pkg::alut_cmd_e             command,
   output logic [31:0]                         prdata,
   output logic                                clear_reused
);

   import alut_reg_pkg::*;

   logic        read_enable;
   logic        write_enable;
   logic        active;           // either checker busy
   logic [31:0] status_word;
   logic [47:0] lst_inv_addr;
   logic [1:0]  lst_inv_port;

   assign read_enable  = psel & ~penable & ~pwrite;    // setup phase
   assign write_enable = psel & penable & pwrite;      // access phase
   assign active       = add_check_active | age_check_active;

   // reading status while idle acknowledges a reuse
   assign clear_reused = read_enable & (paddr == alut_reg_pkg::status) & ~active;

   always_comb
   begin
      status_word              = '0;
      status_word[STAT_ACTIVE] = active;
      status_word[STAT_INVAL]  = inval_in_prog;
      status_word[STAT_REUSED] = reused;
   end

   // ----------------------------------------------------------------------
   // read mux
   // ----------------------------------------------------------------------
   always_ff @(posedge pclk24 or negedge n_p_reset24)
   begin
      if (!n_p_reset24)
         prdata <= '0;
      else if (read_enable)
      begin
         case (paddr)
            alut_reg_pkg::frm_d_addr_l   : prdata <= frame.d_addr[31:0];
            alut_reg_pkg::frm_d_addr_u   : prdata <= {16'd0, frame.d_addr[47:32]};
            alut_reg_pkg::frm_s_addr_l   : prdata <= frame.s_addr[31:0];
            alut_reg_pkg::frm_s_addr_u   : prdata <= {16'd0, frame.s_addr[47:32]};
            alut_reg_pkg::s_port         : prdata <= {30'd0, frame.s_port};
            alut_reg_pkg::d_port         : prdata <= {27'd0, d_port};
            alut_reg_pkg::mac_addr_l     : prdata <= mac_addr[31:0];
            alut_reg_pkg::mac_addr_u     : prdata <= {16'd0, mac_addr[47:32]};
            alut_reg_pkg::cur_time       : prdata <= curr_time;
            alut_reg_pkg::bb_age         : prdata <= best_bfr_age;
            alut_reg_pkg::div_clk        : prdata <= {24'd0, div_clk};
            alut_reg_pkg::status         : prdata <= status_word;
            alut_reg_pkg::lst_inv_addr_l : prdata <= lst_inv_addr[31:0];
            alut_reg_pkg::lst_inv_addr_u : prdata <= {16'd0, lst_inv_addr[47:32]};
            alut_reg_pkg::lst_inv_port   : prdata <= {30'd0, lst_inv_port};
            default                      : prdata <= '0;   // command and holes
         endcase
      end
      else
         prdata <= '0;                 // valid for one cycle only
   end

   // ----------------------------------------------------------------------
   // writable registers
   // ----------------------------------------------------------------------
   always_ff @(posedge pclk24 or negedge n_p_reset24)
   begin
      if (!n_p_reset24)
      begin
         frame        <= '0;
         mac_addr     <= '0;
         best_bfr_age <= BB_AGE_RESET;
         div_clk      <= '0;
      end
      else if (write_enable)
      begin
         case (paddr)
            alut_reg_pkg::frm_d_addr_l : frame.d_addr[31:0]  <= pwdata;
            alut_reg_pkg::frm_d_addr_u : frame.d_addr[47:32] <= pwdata[15:0];
            alut_reg_pkg::frm_s_addr_l : frame.s_addr[31:0]  <= pwdata;
            alut_reg_pkg::frm_s_addr_u : frame.s_addr[47:32] <= pwdata[15:0];
            alut_reg_pkg::s_port       : frame.s_port        <= pwdata[1:0];
            alut_reg_pkg::mac_addr_l   : mac_addr[31:0]      <= pwdata;
            alut_reg_pkg::mac_addr_u   : mac_addr[47:32]     <= pwdata[15:0];
            alut_reg_pkg::bb_age       : best_bfr_age        <= pwdata;
            alut_reg_pkg::div_clk      : div_clk             <= pwdata[7:0];
            default                    : ;
         endcase
      end
   end

   // command pulse, cleared again on the next edge
   always_ff @(posedge pclk24 or negedge n_p_reset24)
   begin
      if (!n_p_reset24)
         command <= cmd_none;
      else if (command != cmd_none)
         command <= cmd_none;
      else if (write_enable && paddr == alut_reg_pkg::command && pwdata[1:0] != 2'd3)
         command <= alut_cmd_e'(pwdata[1:0]);
   end

   // last invalidated entry, a reuse wins over an aged entry
   always_ff @(posedge pclk24 or negedge n_p_reset24)
   begin
      if (!n_p_reset24)
      begin
         lst_inv_addr <= '0;
         lst_inv_port <= '0;
      end
      else if (reused)
      begin
         lst_inv_addr <= lst_inv_nrm.addr;
         lst_inv_port <= lst_inv_nrm.port;
      end
      else if (inval_in_prog)
      begin
         lst_inv_addr <= lst_inv_cmd.addr;
         lst_inv_port <= lst_inv_cmd.port;
      end
   end

   // a legal command write reaches the checkers on the next cycle
   a_cmd_pulse: assert property (@(posedge pclk24) disable iff (!n_p_reset24)
      (write_enable && paddr == alut_reg_pkg::command && command == cmd_none &&
       pwdata[1:0] inside {cmd_check, cmd_age})
      |=> command == alut_cmd_e'($past(pwdata[1:0])));

endmodule

`default_nettype wire

/* alut/alut_table_arbiter.sv */
// 16-slot address table in flops behind a fixed-priority arbiter
// the address checker always wins, the age checker waits with its request held
// read data returns one cycle after the grant, writes land at the grant edge
`timescale 1ns/1ps
`default_nettype none

module alut_table_arbiter (
   input  wire                                 pclk24,
   input  wire                                 n_p_reset24,
   input  wire  alut_table_pkg::alut_mem_req_t chk_req,
   input  wire  alut_table_pkg::alut_mem_req_t age_req,
   output logic                                chk_grant,
   output logic                                age_grant,
   output logic                                chk_rvalid,
   output logic                                age_rvalid,
   output alut_table_pkg::alut_entry_t         rentry
);

   import alut_table_pkg::*;

   alut_mem_req_t          sel;                     // winning request
   logic [TABLE_DEPTH-1:0] valid_q;
   alut_entry_t            mem_q [TABLE_DEPTH];
   logic                   rd_q;                    // read issued last cycle
   logic                   owner_chk_q;             // ... and by whom

   assign chk_grant  = chk_req.req;
   assign age_grant  = age_req.req & ~chk_req.req;
   assign sel        = chk_req.req ? chk_req : age_req;
   assign chk_rvalid = rd_q & owner_chk_q;
   assign age_rvalid = rd_q & ~owner_chk_q;

   // valid bits reset so the table starts empty
   always_ff @(posedge pclk24 or negedge n_p_reset24)
   begin
      if (!n_p_reset24)
      begin
         valid_q     <= '0;
         rd_q        <= 1'b0;
         owner_chk_q <= 1'b0;
      end
      else
      begin
         rd_q        <= sel.req & ~sel.we;
         owner_chk_q <= chk_req.req;
         if (sel.req && sel.we)
            valid_q[sel.idx] <= sel.wentry.valid;
      end
   end

   always_ff @(posedge pclk24)
   begin
      if (sel.req && sel.we)
         mem_q[sel.idx] <= sel.wentry;
      if (sel.req && !sel.we)
      begin
         rentry       <= mem_q[sel.idx];
         rentry.valid <= valid_q[sel.idx];   // payload flag is not trusted
      end
   end

   // read data goes back to the requester that was granted the read
   a_chk_rd_route: assert property (@(posedge pclk24) disable iff (!n_p_reset24)
      (chk_grant && !chk_req.we) |=> (chk_rvalid && !age_rvalid));

   a_age_rd_route: assert property (@(posedge pclk24) disable iff (!n_p_reset24)
      (age_grant && !age_req.we) |=> (age_rvalid && !chk_rvalid));

endmodule

`default_nettype wire

/* common/alut_reg_pkg.sv */
// software view of the lookup block: APB byte addresses, commands, frame fields
// registers are 32 bits wide, upper address halves hold 16 bits
// addresses outside the map read as zero
`default_nettype none

package alut_reg_pkg;

   typedef enum logic [6:0] {
      frm_d_addr_l   = 7'h00,
      frm_d_addr_u   = 7'h04,
      frm_s_addr_l   = 7'h08,
      frm_s_addr_u   = 7'h0C,
      s_port         = 7'h10,
      d_port         = 7'h14,       // read only, lookup result
      mac_addr_l     = 7'h18,
      mac_addr_u     = 7'h1C,
      cur_time       = 7'h20,       // read only
      bb_age         = 7'h24,
      div_clk        = 7'h28,
      command        = 7'h2C,       // write only, reads zero
      status         = 7'h30,
      lst_inv_addr_l = 7'h34,
      lst_inv_addr_u = 7'h38,
      lst_inv_port   = 7'h3C
   } alut_reg_e;

   typedef enum logic [1:0] {
      cmd_none  = 2'd0,
      cmd_check = 2'd1,             // lookup destination, learn source
      cmd_age   = 2'd2              // sweep table for stale entries
   } alut_cmd_e;

   typedef struct packed {
      logic [47:0] d_addr;
      logic [47:0] s_addr;
      logic [1:0]  s_port;
   } alut_frame_t;

   // status register bits
   localparam int STAT_ACTIVE = 0;
   localparam int STAT_INVAL  = 1;
   localparam int STAT_REUSED = 2;

   localparam logic [31:0] BB_AGE_RESET = 32'hffff_ffff;   // nothing ages by default

endpackage

`default_nettype wire

/* common/alut_table_pkg.sv */
// geometry and transfer types of the direct-mapped address table
// one slot per index, no chaining, a collision overwrites the slot
`default_nettype none

package alut_table_pkg;

   localparam int TABLE_DEPTH = 16;
   localparam int IDX_W       = 4;
   localparam int N_PORTS     = 4;

   typedef struct packed {
      logic        valid;
      logic [47:0] mac;
      logic [1:0]  port;
      logic [31:0] stamp;          // curr_time when learned
   } alut_entry_t;

   typedef struct packed {
      logic             req;       // held until granted
      logic             we;        // 0 = read
      logic [IDX_W-1:0] idx;
      alut_entry_t      wentry;
   } alut_mem_req_t;

   typedef struct packed {
      logic [47:0] addr;
      logic [1:0]  port;
   } alut_inv_t;

   // slot index, low nibble xor next nibble of the address
   function automatic logic [IDX_W-1:0] slot_idx(input logic [47:0] addr);
      return addr[3:0] ^ addr[7:4];
   endfunction

endpackage

`default_nettype wire

/* design/alut_top.sv */
// address lookup block of the four-port switch, APB slave only
// no pready/pslverr, every access completes in two cycles
`timescale 1ns/1ps
`default_nettype none

module alut_top (
   input  wire        pclk24,
   input  wire        n_p_reset24,
   input  wire        psel,
   input  wire        penable,
   input  wire        pwrite,
   input  wire [6:0]  paddr,
   input  wire [31:0] pwdata,
   output wire [31:0] prdata
);

   import alut_reg_pkg::*;
   import alut_table_pkg::*;

   // ----------------------------------------------------------------------
   // register bank to checkers
   // ----------------------------------------------------------------------
   wire alut_frame_t      frame;
   wire [47:0]            mac_addr;
   wire [31:0]            best_bfr_age;
   wire [7:0]             div_clk;
   wire alut_cmd_e        command;
   wire                   clear_reused;

   // checkers back to register bank
   wire [31:0]            curr_time;
   wire                   add_check_active;
   wire                   age_check_active;
   wire                   inval_in_prog;
   wire                   reused;
   wire [N_PORTS:0]       d_port;
   wire alut_inv_t        lst_inv_nrm;
   wire alut_inv_t        lst_inv_cmd;

   // table access
   wire alut_mem_req_t    chk_req;
   wire alut_mem_req_t    age_req;
   wire                   chk_grant;
   wire                   age_grant;
   wire                   chk_rvalid;
   wire                   age_rvalid;
   wire alut_entry_t      rentry;

   alut_reg_bank reg_bank_i (.*);

   alut_addr_checker addr_chk_i (
      .*,
      .mem_req (chk_req),
      .grant   (chk_grant),
      .rvalid  (chk_rvalid)
   );

   alut_age_checker age_chk_i (
      .*,
      .mem_req (age_req),
      .grant   (age_grant),
      .rvalid  (age_rvalid)
   );

   alut_table_arbiter arb_i (.*);

endmodule

`default_nettype wire

/* verif/alut_tb.sv */
// testbench of the lookup block, APB driven on the falling clock edge
// a 16-slot model predicts lookups, reuse and aging
// entry ages are tracked in clock cycles, margins keep them far from bb_age
// stops at the first error
`timescale 1ns/1ps
`default_nettype none

module alut_tb;

   import alut_reg_pkg::*;

   typedef struct packed {
      logic        valid;
      logic [47:0] mac;
      logic [1:0]  port;
      logic [31:0] stamp;           // cycle count when learned
   } slot_t;

   logic        pclk24;
   logic        n_p_reset24;
   logic        psel;
   logic        penable;
   logic        pwrite;
   logic [6:0]  paddr;
   logic [31:0] pwdata;
   logic [31:0] prdata;

   integer      seed = 40640;
   logic [31:0] cycle_cnt = '0;
   slot_t       model [16];
   logic [47:0] own_mac;
   logic [4:0]  exp_dport;
   logic        exp_reuse;
   logic [47:0] exp_inv_addr;
   logic [1:0]  exp_inv_port;
   logic [47:0] first_stale;      // first entry dropped by the sweep
   int          n_inv;

   alut_top dut_i (
      .pclk24      (pclk24),
      .n_p_reset24 (n_p_reset24),
      .psel        (psel),
      .penable     (penable),
      .pwrite      (pwrite),
      .paddr       (paddr),
      .pwdata      (pwdata),
      .prdata      (prdata)
   );

   initial
   begin
      pclk24 = 1'b0;
      forever #50 pclk24 = ~pclk24;    // 100 ns period
   end

   // watchdog, whole run is about 2500 cycles
   always @(posedge pclk24)
   begin
      cycle_cnt <= cycle_cnt + 32'd1;
      if (cycle_cnt >= 32'd20000)
      begin
         $display("timeout: the run went past 20000 clock cycles");
         $display("Checks failed");
         $fatal(1, "watchdog expired");
      end
   end

   task automatic fail_now(input string msg);
      $display("[ERROR] %0t ns: %s", $time, msg);
      $display("Checks failed");
      $fatal(1, "stopping at first error");
   endtask

   // prdata only carries data in the cycle after a read setup
   a_prdata_quiet: assert property (@(posedge pclk24) disable iff (!n_p_reset24)
      !$past(psel && !penable && !pwrite) |-> prdata == 32'd0)
      else fail_now("prdata not zero outside a read");

   // ---------------------------------------------------------------------
   // APB access
   // ---------------------------------------------------------------------
   task automatic apb_write(input logic [6:0] addr, input logic [31:0] data);
      @(negedge pclk24);
      psel    = 1'b1;               // setup
      penable = 1'b0;
      pwrite  = 1'b1;
      paddr   = addr;
      pwdata  = data;
      @(negedge pclk24);
      penable = 1'b1;               // access, lands on next edge
      @(negedge pclk24);
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic apb_read(input logic [6:0] addr, output logic [31:0] data);
      @(negedge pclk24);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = addr;
      @(negedge pclk24);
      penable = 1'b1;
      data    = prdata;             // captured at setup edge
      @(negedge pclk24);
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic check_eq(input logic [31:0] got, input logic [31:0] want,
                           input string what);
      assert (got === want)
      else fail_now($sformatf("%s read %h, expected %h", what, got, want));
   endtask

   task automatic expect_reg(input logic [6:0] addr, input logic [31:0] want,
                             input string what);
      logic [31:0] got;
      apb_read(addr, got);
      check_eq(got, want, what);
   endtask

   // poll until neither checker is busy
   task automatic wait_idle(output logic [31:0] st);
      apb_read(status, st);
      while (st[STAT_ACTIVE])
         apb_read(status, st);
   endtask

   task automatic rand_mac(output logic [47:0] m);
      logic [63:0] r;
      r = {$random(seed), $random(seed)};
      m = r[47:0];
   endtask

   function automatic logic [3:0] slot_of(input logic [47:0] a);
      return a[3:0] ^ a[7:4];          // low nibble xor next nibble
   endfunction

   // ---------------------------------------------------------------------
   // model
   // ---------------------------------------------------------------------
   task automatic predict_check(input logic [47:0] d, input logic [47:0] s,
                                input logic [1:0] sp);
      slot_t dst;
      slot_t src;
      dst = model[slot_of(d)];             // read before the source write
      if (d == own_mac)
         exp_dport = 5'b1_0000;
      else if (dst.valid && dst.mac == d)
         exp_dport = 5'b0_0001 << dst.port;
      else
         exp_dport = {1'b0, ~(4'b0001 << sp)};    // flood but not back out
      src          = model[slot_of(s)];
      exp_reuse    = src.valid && (src.mac != s);
      exp_inv_addr = src.mac;
      exp_inv_port = src.port;
      model[slot_of(s)] = '{valid: 1'b1, mac: s, port: sp, stamp: cycle_cnt};
   endtask

   // sweep order 0..15, last drop ends up in lst_inv
   task automatic predict_sweep(input logic [31:0] max_age);
      n_inv = 0;
      for (int i = 0; i < 16; i++)
      begin
         if (model[i].valid && (cycle_cnt - model[i].stamp) > max_age)
         begin
            if (n_inv == 0)
               first_stale = model[i].mac;
            model[i].valid = 1'b0;
            exp_inv_addr   = model[i].mac;
            exp_inv_port   = model[i].port;
            n_inv++;
         end
      end
   endtask

   task automatic load_frame(input logic [47:0] d, input logic [47:0] s,
                             input logic [1:0] sp);
      apb_write(frm_d_addr_l, d[31:0]);
      apb_write(frm_d_addr_u, {16'd0, d[47:32]});
      apb_write(frm_s_addr_l, s[31:0]);
      apb_write(frm_s_addr_u, {16'd0, s[47:32]});
      apb_write(s_port, {30'd0, sp});
   endtask

   task automatic check_lst_inv();
      expect_reg(lst_inv_addr_l, exp_inv_addr[31:0], "lst_inv_addr_l");
      expect_reg(lst_inv_addr_u, {16'd0, exp_inv_addr[47:32]}, "lst_inv_addr_u");
      expect_reg(lst_inv_port, {30'd0, exp_inv_port}, "lst_inv_port");
   endtask

   task automatic verify_check();
      logic [31:0] st;
      wait_idle(st);
      check_eq(st, {29'd0, exp_reuse, 2'b00}, "status at end of check");
      expect_reg(d_port, {27'd0, exp_dport}, "d_port");
      if (exp_reuse)
         check_lst_inv();
      expect_reg(status, 32'd0, "status after idle read");   // reuse acked
   endtask

   task automatic run_check(input logic [47:0] d, input logic [47:0] s,
                            input logic [1:0] sp);
      load_frame(d, s, sp);
      predict_check(d, s, sp);
      apb_write(command, 32'(cmd_check));
      verify_check();
   endtask

   task automatic check_readback(input logic [6:0] addr, input logic [31:0] mask,
                                 input string what);
      logic [31:0] val;
      val = $random(seed);
      apb_write(addr, val);
      expect_reg(addr, val & mask, what);
   endtask

   // ---------------------------------------------------------------------
   // stimulus
   // ---------------------------------------------------------------------
   initial
   begin
      logic [47:0] d;
      logic [47:0] s;
      logic [47:0] s_first;
      logic [31:0] t0;
      logic [31:0] t1;
      logic [31:0] st;
      psel        = 1'b0;
      penable     = 1'b0;
      pwrite      = 1'b0;
      paddr       = '0;
      pwdata      = '0;
      n_p_reset24 = 1'b0;
      own_mac     = '0;
      for (int i = 0; i < 16; i++)
         model[i] = '0;                   // table starts empty
      repeat (16) @(negedge pclk24);
      n_p_reset24 = 1'b1;

      // reset values, cur_time runs from reset so only its motion counts
      for (int a = 0; a < 64; a += 4)
         if (a != 32'h20)
            expect_reg(7'(a), (a == 32'h24) ? 32'hffff_ffff : 32'd0,
                       $sformatf("reset value at %h", a));
      expect_reg(7'h40, 32'd0, "unmapped address");
      apb_read(cur_time, t0);
      apb_read(cur_time, t1);
      assert (t1 > t0)
      else fail_now("cur_time did not advance");

      // read-back, masked to register widths
      check_readback(frm_d_addr_l, 32'hffff_ffff, "frm_d_addr_l");
      check_readback(frm_d_addr_u, 32'h0000_ffff, "frm_d_addr_u");
      check_readback(frm_s_addr_l, 32'hffff_ffff, "frm_s_addr_l");
      check_readback(frm_s_addr_u, 32'h0000_ffff, "frm_s_addr_u");
      check_readback(s_port, 32'h0000_0003, "s_port");
      check_readback(mac_addr_l, 32'hffff_ffff, "mac_addr_l");
      check_readback(mac_addr_u, 32'h0000_ffff, "mac_addr_u");
      check_readback(bb_age, 32'hffff_ffff, "bb_age");
      check_readback(div_clk, 32'h0000_00ff, "div_clk");
      apb_write(command, 32'd3);              // illegal opcode, no effect
      expect_reg(command, 32'd0, "command");
      apb_write(div_clk, 32'd0);              // time base back to every cycle
      apb_write(bb_age, 32'hffff_ffff);
      rand_mac(own_mac);
      apb_write(mac_addr_l, own_mac[31:0]);
      apb_write(mac_addr_u, {16'd0, own_mac[47:32]});

      // lookup and learn
      rand_mac(d);
      rand_mac(s_first);
      run_check(d, s_first, 2'd2);
      assert (exp_dport == 5'b0_1011)
      else fail_now("first lookup was not an unknown destination");
      rand_mac(s);
      run_check(s_first, s, 2'd0);
      assert (exp_dport == 5'b0_0100)
      else fail_now("learned source was not hit");
      rand_mac(s);
      run_check(own_mac, s, 2'd1);
      for (int k = 0; k < 6; k++)
      begin
         rand_mac(s);
         if (k[0])
            d = s_first;
         else
            rand_mac(d);
         run_check(d, s, 2'(k));
      end

      // reuse, second source hits the same slot
      rand_mac(s_first);
      rand_mac(d);
      run_check(d, s_first, 2'd1);
      s = s_first ^ 48'h11;                    // same nibble xor, other mac
      rand_mac(d);
      run_check(d, s, 2'd3);
      assert (exp_reuse)
      else fail_now("colliding sources did not hit an occupied slot");

      // -------------------------------------------------------------------
      // aging
      // -------------------------------------------------------------------
      apb_write(bb_age, 32'd400);
      repeat (1000) @(negedge pclk24);         // everything so far goes stale
      rand_mac(d);
      rand_mac(s);
      run_check(d, s, 2'd3);                   // one fresh entry survives
      predict_sweep(32'd400);
      assert (n_inv > 0)
      else fail_now("no stale entry before the sweep");
      apb_write(command, 32'(cmd_age));
      wait_idle(st);
      check_eq(st & ~32'h2, 32'd0, "status at end of sweep");
      expect_reg(status, 32'd0, "status after sweep");
      check_lst_inv();
      rand_mac(s);
      run_check(first_stale, s, 2'd0);
      assert (exp_dport == 5'b0_1110)
      else fail_now("aged destination not flooded");

      // contention, check overtakes a running sweep
      apb_write(bb_age, 32'hffff_ffff);
      d = s;                                   // just learned
      rand_mac(s);
      load_frame(d, s, 2'd2);
      predict_check(d, s, 2'd2);
      predict_sweep(32'hffff_ffff);
      apb_write(command, 32'(cmd_age));
      apb_write(command, 32'(cmd_check));
      verify_check();

      $display("All checks passed");
      $finish;
   end

endmodule

`default_nettype wire

/* verilog.f */
common/alut_reg_pkg.sv
common/alut_table_pkg.sv
alut/alut_reg_bank.sv
alut/alut_addr_checker.sv
alut/alut_age_checker.sv
alut/alut_table_arbiter.sv
design/alut_top.sv
verif/alut_tb.sv
